// ==== Makefile ====
TOP = core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf obj_dir

// ==== src.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/core.sv
tests/core_tb.sv

// ==== tests/core_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module core_tb;

	localparam int PRE_WORDS   = 64;                     // Words reached by LW/SW
	localparam int RAND_LEN    = 200;
	localparam int PROG_LEN    = 10 + RAND_LEN + 31;     // Directed head, random body, SW dump
	localparam int DUMP_BASE   = 512;                    // x1 lands here
	localparam int PORT_BASE   = 700;
	localparam int PORT_WORDS  = 64;
	localparam int PORT_WRITES = 128;
	localparam int RUN_CYCLES  = PROG_LEN * 2 + 100;
	// Port traffic takes two cycles a write and at most three a read
	localparam int WD_CYCLES   = RUN_CYCLES + (PRE_WORDS + PORT_WORDS + PORT_WRITES) * 2
		+ (31 + PRE_WORDS + PORT_WORDS) * 3 + 20;
	localparam logic [31:0] NOP    = 32'h0000_0013;    // ADDI x0, x0, 0
	// {alt, funct3} per ALU code with code 0 in the low nibble
	localparam logic [39:0] FUNCTS = 40'h76d5_4321_80;

	logic                        clk;
	logic                        arst_n;
	logic [`CORE_PC_W-1:0]       fetch_addr;
	logic [`CORE_XLEN-1:0]       inst;
	logic [`CORE_BE_W-1:0]       con_write;
	logic [`CORE_DM_ADDR_W-1:0]  con_addr;
	logic [`CORE_XLEN-1:0]       con_in;
	logic [`CORE_XLEN-1:0]       con_out;

	logic [31:0] imem [0:2**(`CORE_PC_W-2)-1];    // What the core fetches
	logic [31:0] prog [0:PROG_LEN-1];
	logic [31:0] mregs [0:31];                    // Model registers
	logic [31:0] mmem [0:`CORE_DM_WORDS-1];       // Model data memory
	logic [11:0] seen [0:12];                     // fetch_addr per cycle after reset
	integer      seed;
	string       cur_name;
	int          checks;
	int          errs;
	int          tests_run;
	int          tests_failed;
	int          checks_total;
	int          errs_total;

	core u_core (
		.clk        (clk),
		.arst_n     (arst_n),
		.fetch_addr (fetch_addr),
		.inst       (inst),
		.con_write  (con_write),
		.con_addr   (con_addr),
		.con_in     (con_in),
		.con_out    (con_out)
	);

	assign inst = imem[fetch_addr[`CORE_PC_W-1:2]];    // Same-cycle answer

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog
	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the run never reached its end", WD_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// RV32I semantics for codes add sub sll slt sltu xor srl sra or and
	function automatic logic [31:0] alu_ref(input int code, input logic [31:0] a,
		input logic [31:0] b);
		case (code)
			0: return a + b;
			1: return a - b;
			2: return a << b[4:0];
			3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4: return (a < b) ? 32'd1 : 32'd0;
			5: return a ^ b;
			6: return a >> b[4:0];
			7: return $unsigned($signed(a) >>> b[4:0]);
			8: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] r_type(input int code, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic [3:0] fb;
		fb = FUNCTS[code*4 +: 4];
		return {1'b0, fb[3], 5'b0, rs2, rs1, fb[2:0], rd, 7'h33};    // funct7 0x20 for alt
	endfunction

	function automatic logic [31:0] load_inst(input logic [4:0] rd, input int word);
		logic [11:0] off;
		off = 12'(word * 4);
		return {off, 5'd0, 3'b010, rd, 7'h03};    // LW rd, off(x0)
	endfunction

	function automatic logic [31:0] store_inst(input logic [4:0] rs2, input int word);
		logic [11:0] off;
		off = 12'(word * 4);    // Past 2047 it wraps negative but bits 11:2 still pick the word
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};
	endfunction

	task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
		if (rd != 5'd0) mregs[rd] = val;    // x0 stays zero
	endtask

	// One random instruction, encoded and executed on the model
	task automatic add_random(input int idx, input bit mem_ok);
		int          kind;
		int          code;
		int          word;
		logic [3:0]  fb;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [19:0] upper;
		kind  = $unsigned($random(seed)) % (mem_ok ? 22 : 20);
		word  = $unsigned($random(seed)) % PRE_WORDS;
		rd    = 5'($random(seed));
		rs1   = 5'($random(seed));
		rs2   = 5'($random(seed));
		imm   = 12'($random(seed));
		upper = 20'($random(seed));
		if (kind < 10) begin    // Register ALU
			prog[idx] = r_type(kind, rd, rs1, rs2);
			write_reg(rd, alu_ref(kind, mregs[rs1], mregs[rs2]));
		end else if (kind < 19) begin    // Immediate ALU
			code = kind - 10;
			if (code >= 1) code++;    // No SUBI
			fb = FUNCTS[code*4 +: 4];
			if (code == 2 || code == 6 || code == 7) imm = {fb[3] ? 7'h20 : 7'h00, imm[4:0]};
			prog[idx] = {imm, rs1, fb[2:0], rd, 7'h13};
			write_reg(rd, alu_ref(code, mregs[rs1], {{20{imm[11]}}, imm}));
		end else if (kind == 19) begin
			prog[idx] = {upper, rd, 7'h37};    // LUI
			write_reg(rd, {upper, 12'b0});
		end else if (kind == 20) begin
			prog[idx] = load_inst(rd, word);
			write_reg(rd, mmem[word]);
		end else begin
			prog[idx] = store_inst(rs2, word);
			mmem[word] = mregs[rs2];
		end
	endtask

	//////////////////////////////
	// Checks and port traffic
	//////////////////////////////

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, got);
			errs++;
		end
	endtask

	task automatic end_test();
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("Test %0d %s: %0d checks, %0d errors", tests_run, cur_name, checks, errs);
		checks_total += checks;
		errs_total   += errs;
		checks = 0;
		errs   = 0;
	endtask

	task automatic write_port(input int word, input logic [3:0] be, input logic [31:0] data);
		@(posedge clk);
		con_write <= be;
		con_addr  <= 10'(word);
		con_in    <= data;
		@(posedge clk);    // Write lands here
		con_write <= '0;
	endtask

	task automatic read_port(input int word, output logic [31:0] data);
		@(posedge clk);
		con_addr <= 10'(word);
		@(posedge clk);    // Registered read
		@(negedge clk);
		data = con_out;
	endtask

	initial begin
		int         c;
		int         w;
		logic [31:0] got;
		logic [31:0] d;
		logic [3:0]  be;
		seed      = 32'h819b;
		arst_n    = 1'b0;
		con_write = '0;
		con_addr  = '0;
		con_in    = '0;
		checks    = 0;
		errs      = 0;
		tests_run = 0;
		tests_failed = 0;
		checks_total = 0;
		errs_total   = 0;
		for (c = 0; c < 2**(`CORE_PC_W-2); c++) imem[c] = NOP;
		for (c = 0; c < 32; c++) mregs[c] = '0;
		for (c = 0; c < PRE_WORDS; c++) mmem[c] = $random(seed);

		// Head has no loads, then LW x5 and a dependent ADD
		for (c = 0; c < 8; c++) add_random(c, 1'b0);
		prog[8] = load_inst(5'd5, 3);
		write_reg(5'd5, mmem[3]);
		prog[9] = r_type(0, 5'd6, 5'd5, 5'd5);
		write_reg(5'd6, mregs[5] + mregs[5]);
		for (c = 10; c < 10 + RAND_LEN; c++) add_random(c, 1'b1);
		for (c = 1; c < 32; c++) prog[9 + RAND_LEN + c] = store_inst(5'(c), DUMP_BASE + c - 1);

		// Preload data words while the core spins on NOPs
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		for (w = 0; w < PRE_WORDS; w++) write_port(w, 4'hf, mmem[w]);

		cur_name = "reset_step";
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		for (c = 0; c < PROG_LEN; c++) imem[c] = prog[c];
		check_value("fetch_addr in reset", 32'd0, 32'(fetch_addr));
		@(negedge clk);
		check_value("fetch_addr in reset", 32'd0, 32'(fetch_addr));
		@(posedge clk);
		arst_n <= 1'b1;
		for (c = 0; c < 13; c++) begin
			@(negedge clk);
			seen[c] = fetch_addr;
		end
		for (c = 0; c <= 10; c++) check_value($sformatf("cycle %0d", c), 32'(4 * c), 32'(seen[c]));
		end_test();

		// Stall shows up in cycle 10 when the ADD meets the LW
		cur_name = "load_use_stall";
		check_value("held fetch_addr", 32'(4 * 10), 32'(seen[11]));
		check_value("fetch_addr after hold", 32'(4 * 11), 32'(seen[12]));
		end_test();

		// Drain, then park the core on NOPs
		while (fetch_addr < 12'(4 * (PROG_LEN + 8))) @(negedge clk);
		for (c = 0; c < 2**(`CORE_PC_W-2); c++) imem[c] = NOP;

		cur_name = "register_results";
		for (c = 1; c < 32; c++) begin
			read_port(DUMP_BASE + c - 1, got);
			check_value($sformatf("x%0d", c), mregs[c], got);
		end
		end_test();

		cur_name = "memory_results";
		for (w = 0; w < PRE_WORDS; w++) begin
			read_port(w, got);
			check_value($sformatf("word %0d", w), mmem[w], got);
		end
		end_test();

		cur_name = "protocol_port";
		for (w = 0; w < PORT_WORDS; w++) begin    // Known contents first
			d = $random(seed);
			mmem[PORT_BASE + w] = d;
			write_port(PORT_BASE + w, 4'hf, d);
		end
		for (c = 0; c < PORT_WRITES; c++) begin
			w  = PORT_BASE + $unsigned($random(seed)) % PORT_WORDS;
			be = 4'($random(seed));
			d  = $random(seed);
			for (int b = 0; b < `CORE_BE_W; b++) begin
				if (be[b]) mmem[w][b*8 +: 8] = d[b*8 +: 8];    // Byte merge
			end
			write_port(w, be, d);
		end
		for (w = PORT_BASE; w < PORT_BASE + PORT_WORDS; w++) begin
			read_port(w, got);
			check_value($sformatf("word %0d", w), mmem[w], got);
		end
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks_total, errs_total);
		if (errs_total == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/core.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module core (
	input  wire                         clk,
	input  wire                         arst_n,
	output logic [`CORE_PC_W-1:0]       fetch_addr,    // To external instruction memory
	input  wire  [`CORE_XLEN-1:0]       inst,          // Answers fetch_addr same cycle
	input  wire  [`CORE_BE_W-1:0]       con_write,
	input  wire  [`CORE_DM_ADDR_W-1:0]  con_addr,
	input  wire  [`CORE_XLEN-1:0]       con_in,
	output logic [`CORE_XLEN-1:0]       con_out        // One cycle after con_addr
);

	logic                  stall;
	logic [`CORE_XLEN-1:0] id_inst;
	core_pkg::id_ex_t      id_ex;
	core_pkg::ex_mem_t     ex_mem;
	core_pkg::mem_wb_t     mem_wb;    // Register write and EX forward

	//////////////////////////////
	// Pipeline stages
	//////////////////////////////

	fetch_stage u_fetch_stage (
		.clk     (clk),
		.arst_n  (arst_n),
		.stall   (stall),
		.inst    (inst),
		.if_pc   (fetch_addr),
		.id_inst (id_inst)
	);

	decode_stage u_decode_stage (
		.clk     (clk),
		.arst_n  (arst_n),
		.id_inst (id_inst),
		.wb      (mem_wb),
		.ex_out  (id_ex),
		.stall   (stall)
	);

	execute_stage u_execute_stage (
		.clk     (clk),
		.arst_n  (arst_n),
		.ex_in   (id_ex),
		.mem_fwd (ex_mem),
		.wb_fwd  (mem_wb)
	);

	memory_stage u_memory_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_in    (ex_mem),
		.con_write (con_write),
		.con_addr  (con_addr),
		.con_in    (con_in),
		.con_out   (con_out),
		.wb_out    (mem_wb)
	);

endmodule

`default_nettype wire

// ==== verilog/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define CORE_XLEN 32         // Register and bus width
`define CORE_PC_W 12         // Fetch address bits
`define CORE_PC_STEP 4       // One word per fetch

// Register file index
`define CORE_REG_ADDR_W 5

//////////////////////////////
// Data memory
//////////////////////////////

`define CORE_DM_ADDR_W 10    // Word address, both ports
`define CORE_DM_WORDS 1024   // 4 KB of words

// Protocol port byte lanes
`define CORE_BE_W 4

`endif

// ==== verilog/core_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package core_pkg;

	// Major opcodes kept from RV32I
	typedef enum logic [6:0] {
		op_reg   = 7'h33,    // R-type ALU
		op_imm   = 7'h13,    // I-type ALU
		op_lui   = 7'h37,
		op_load  = 7'h03,    // LW only
		op_store = 7'h23     // SW only
	} opcode_e;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b           // LUI, B straight through
	} alu_op_e;

	//////////////////////////////
	// Stage register contents
	//////////////////////////////

	typedef struct packed {
		alu_op_e alu_op;
		logic    sel_imm;    // Operand B from immediate
		logic    wr_en;      // Register write
		logic    is_load;
		logic    is_store;
	} ctrl_t;

	// Decode to execute
	typedef struct packed {
		ctrl_t                       ctrl;
		logic [`CORE_REG_ADDR_W-1:0] rs_a;    // Zero when unused
		logic [`CORE_REG_ADDR_W-1:0] rs_b;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]       val_a;   // Register file values
		logic [`CORE_XLEN-1:0]       val_b;
		logic [`CORE_XLEN-1:0]       imm;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic                        wr_en;
		logic                        is_load;
		logic                        is_store;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]       alu_res;     // Also load/store address
		logic [`CORE_XLEN-1:0]       store_data;
	} ex_mem_t;

	// Memory to writeback
	typedef struct packed {
		logic                        wr_en;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]       wr_data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module decode_stage (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire  [`CORE_XLEN-1:0] id_inst,
	input  wire  core_pkg::mem_wb_t wb,       // Register write from writeback
	output core_pkg::id_ex_t      ex_out,
	output logic                  stall       // Load-use hold of one cycle
);

	core_pkg::opcode_e            opcode;
	logic [2:0]                   funct3;
	logic [`CORE_REG_ADDR_W-1:0]  rs_a_f;     // Raw instruction fields
	logic [`CORE_REG_ADDR_W-1:0]  rs_b_f;
	logic [`CORE_REG_ADDR_W-1:0]  rd_f;
	logic [`CORE_XLEN-1:0]        rf_a;
	logic [`CORE_XLEN-1:0]        rf_b;
	logic [`CORE_XLEN-1:0]        imm;
	logic                         uses_a;
	logic                         uses_b;
	core_pkg::ctrl_t              ctrl;
	core_pkg::id_ex_t             id_next;

	assign opcode = core_pkg::opcode_e'(id_inst[6:0]);
	assign funct3 = id_inst[14:12];
	assign rs_a_f = id_inst[19:15];
	assign rs_b_f = id_inst[24:20];
	assign rd_f   = id_inst[11:7];

	register_file u_register_file (
		.clk    (clk),
		.arst_n (arst_n),
		.wb     (wb),
		.rs_a   (rs_a_f),
		.rs_b   (rs_b_f),
		.rd_a   (rf_a),
		.rd_b   (rf_b)
	);

	// funct3 to ALU op with alt picking SUB or SRA
	function automatic core_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? core_pkg::alu_sub : core_pkg::alu_add;
			3'd1:    return core_pkg::alu_sll;
			3'd2:    return core_pkg::alu_slt;
			3'd3:    return core_pkg::alu_sltu;
			3'd4:    return core_pkg::alu_xor;
			3'd5:    return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'd6:    return core_pkg::alu_or;
			default: return core_pkg::alu_and;
		endcase
	endfunction

	//////////////////////////////
	// Control and immediate
	//////////////////////////////

	always_comb begin
		ctrl   = '0;    // ADD, no write, no store
		imm    = '0;
		uses_a = 1'b0;
		uses_b = 1'b0;
		case (opcode)
			core_pkg::op_reg: begin
				ctrl.alu_op = alu_from_funct(funct3, id_inst[30]);
				ctrl.wr_en  = 1'b1;
				uses_a      = 1'b1;
				uses_b      = 1'b1;
			end
			core_pkg::op_imm: begin
				ctrl.alu_op  = alu_from_funct(funct3, (funct3 == 3'd5) && id_inst[30]);    // No SUBI
				ctrl.sel_imm = 1'b1;
				ctrl.wr_en   = 1'b1;
				uses_a       = 1'b1;
				imm          = {{20{id_inst[31]}}, id_inst[31:20]};    // I-type
			end
			core_pkg::op_lui: begin
				ctrl.alu_op  = core_pkg::alu_pass_b;
				ctrl.sel_imm = 1'b1;
				ctrl.wr_en   = 1'b1;
				imm          = {id_inst[31:12], 12'b0};    // U-type
			end
			core_pkg::op_load: begin
				ctrl.sel_imm = 1'b1;
				ctrl.wr_en   = 1'b1;
				ctrl.is_load = 1'b1;
				uses_a       = 1'b1;
				imm          = {{20{id_inst[31]}}, id_inst[31:20]};
			end
			core_pkg::op_store: begin
				ctrl.sel_imm  = 1'b1;
				ctrl.is_store = 1'b1;
				uses_a        = 1'b1;
				uses_b        = 1'b1;    // Store data
				imm           = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};    // S-type
			end
			default: ;    // Retires as NOP
		endcase
	end

	// Unused sources go out as x0 so nothing forwards into them
	assign id_next = '{
		ctrl:  ctrl,
		rs_a:  uses_a ? rs_a_f : '0,
		rs_b:  uses_b ? rs_b_f : '0,
		rd:    rd_f,
		val_a: rf_a,
		val_b: rf_b,
		imm:   imm
	};

	// Load in execute feeding this instruction
	assign stall = ex_out.ctrl.is_load && (ex_out.rd != '0)
		&& ((uses_a && rs_a_f == ex_out.rd) || (uses_b && rs_b_f == ex_out.rd));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_out <= '0;
		end else if (stall) begin
			ex_out <= '0;    // Bubble
		end else begin
			ex_out <= id_next;
		end
	end

	// Fetch keeps the stalled instruction for the retry
	a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> $stable(id_inst));

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module execute_stage (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire  core_pkg::id_ex_t   ex_in,
	output core_pkg::ex_mem_t        mem_fwd,    // Also read back for forwarding
	input  wire  core_pkg::mem_wb_t  wb_fwd
);

	logic [`CORE_XLEN-1:0] op_a;
	logic [`CORE_XLEN-1:0] fwd_b;      // rs_b after forwarding, store data too
	logic [`CORE_XLEN-1:0] op_b;
	logic [`CORE_XLEN-1:0] alu_res;
	logic [4:0]            shamt;

	//////////////////////////////
	// Forwarding
	//////////////////////////////

	// Memory stage first, loads excluded, then writeback
	function automatic logic [`CORE_XLEN-1:0] fwd_pick(
		input logic [`CORE_REG_ADDR_W-1:0] rs,
		input logic [`CORE_XLEN-1:0]       dec_val,
		input core_pkg::ex_mem_t           mem,
		input core_pkg::mem_wb_t           wb
	);
		if (rs != '0 && mem.wr_en && !mem.is_load && mem.rd == rs) return mem.alu_res;
		if (rs != '0 && wb.wr_en && wb.rd == rs) return wb.wr_data;
		return dec_val;
	endfunction

	assign op_a  = fwd_pick(ex_in.rs_a, ex_in.val_a, mem_fwd, wb_fwd);
	assign fwd_b = fwd_pick(ex_in.rs_b, ex_in.val_b, mem_fwd, wb_fwd);
	assign op_b  = ex_in.ctrl.sel_imm ? ex_in.imm : fwd_b;
	assign shamt = op_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (ex_in.ctrl.alu_op)
			core_pkg::alu_add:    alu_res = op_a + op_b;    // Also load/store address
			core_pkg::alu_sub:    alu_res = op_a - op_b;
			core_pkg::alu_sll:    alu_res = op_a << shamt;
			core_pkg::alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			core_pkg::alu_sltu:   alu_res = {31'b0, op_a < op_b};
			core_pkg::alu_xor:    alu_res = op_a ^ op_b;
			core_pkg::alu_srl:    alu_res = op_a >> shamt;
			core_pkg::alu_sra:    alu_res = $unsigned($signed(op_a) >>> shamt);
			core_pkg::alu_or:     alu_res = op_a | op_b;
			core_pkg::alu_and:    alu_res = op_a & op_b;
			core_pkg::alu_pass_b: alu_res = op_b;    // LUI
			default:              alu_res = '0;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_fwd <= '0;
		end else begin
			mem_fwd.wr_en      <= ex_in.ctrl.wr_en;
			mem_fwd.is_load    <= ex_in.ctrl.is_load;
			mem_fwd.is_store   <= ex_in.ctrl.is_store;
			mem_fwd.rd         <= ex_in.rd;
			mem_fwd.alu_res    <= alu_res;
			mem_fwd.store_data <= fwd_b;
		end
	end

	// Load one ahead with a needed rd means decode missed the stall
	a_no_load_use: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_fwd.is_load && mem_fwd.wr_en && mem_fwd.rd != '0
			&& (mem_fwd.rd == ex_in.rs_a || mem_fwd.rd == ex_in.rs_b)));

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module fetch_stage (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   stall,     // Load-use hold from decode
	input  wire  [`CORE_XLEN-1:0] inst,      // Same-cycle answer to if_pc
	output logic [`CORE_PC_W-1:0] if_pc,
	output logic [`CORE_XLEN-1:0] id_inst
);

	logic [`CORE_PC_W-1:0] pc;

	assign if_pc = pc;    // Straight to the instruction memory

	// Program counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + `CORE_PC_W'(`CORE_PC_STEP);
		end
	end

	//////////////////////////////
	// Fetch/decode register
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_inst <= 32'h0000_0013;    // ADDI x0, x0, 0
		end else if (!stall) begin
			id_inst <= inst;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module memory_stage (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire  core_pkg::ex_mem_t     mem_in,
	input  wire  [`CORE_BE_W-1:0]       con_write,    // Byte enables, protocol side
	input  wire  [`CORE_DM_ADDR_W-1:0]  con_addr,
	input  wire  [`CORE_XLEN-1:0]       con_in,
	output logic [`CORE_XLEN-1:0]       con_out,
	output core_pkg::mem_wb_t           wb_out
);

	localparam int BYTE_W = `CORE_XLEN / `CORE_BE_W;

	logic [`CORE_XLEN-1:0]      dmem [0:`CORE_DM_WORDS-1];
	logic [`CORE_DM_ADDR_W-1:0] core_addr;    // Word address from ALU
	logic [`CORE_XLEN-1:0]      load_data;
	logic                       core_we;

	assign core_addr = mem_in.alu_res[`CORE_DM_ADDR_W+1:2];
	assign load_data = dmem[core_addr];    // Async read, core port

	// Protocol write owns the word on a collision
	assign core_we = mem_in.is_store && !((|con_write) && con_addr == core_addr);

	//////////////////////////////
	// Dual-port data memory
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (core_we) dmem[core_addr] <= mem_in.store_data;    // Whole word
		for (int i = 0; i < `CORE_BE_W; i++) begin
			if (con_write[i]) dmem[con_addr][i*BYTE_W +: BYTE_W] <= con_in[i*BYTE_W +: BYTE_W];
		end
		con_out <= dmem[con_addr];    // Registered read, old data on write
	end

	// Memory/writeback register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_out <= '0;
		end else begin
			wb_out.wr_en   <= mem_in.wr_en;
			wb_out.rd      <= mem_in.rd;
			wb_out.wr_data <= mem_in.is_load ? load_data : mem_in.alu_res;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "core_consts.svh"

module register_file (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire  core_pkg::mem_wb_t      wb,      // Write port from writeback
	input  wire  [`CORE_REG_ADDR_W-1:0]  rs_a,
	input  wire  [`CORE_REG_ADDR_W-1:0]  rs_b,
	output logic [`CORE_XLEN-1:0]        rd_a,
	output logic [`CORE_XLEN-1:0]        rd_b
);

	logic [`CORE_XLEN-1:0] regs [1:2**`CORE_REG_ADDR_W-1];    // x1..x31 with no storage for x0
	logic                  we;

	assign we = wb.wr_en && (wb.rd != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 2**`CORE_REG_ADDR_W; i++) regs[i] <= '0;
		end else if (we) begin
			regs[wb.rd] <= wb.wr_data;
		end
	end

	// Reads see a same-cycle write, so WB to decode needs no forward
	assign rd_a = (rs_a == '0) ? '0 : (we && wb.rd == rs_a) ? wb.wr_data : regs[rs_a];
	assign rd_b = (rs_b == '0) ? '0 : (we && wb.rd == rs_b) ? wb.wr_data : regs[rs_b];

endmodule

`default_nettype wire
